//--- build.f
src/icache_pkg.sv
src/icache_tag_store.sv
src/icache_age_tracker.sv
src/icache_data_store.sv
src/icache_ctrl.sv
src/icache_top.sv
verification/icache_tb.sv

//--- src/icache_age_tracker.sv
// per-set saturating ages for both ways
// victim choice, invalid way first and then the older way
module icache_age_tracker #(
    parameter int AGE_W = 3
) (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [icache_pkg::INDEX_W-1:0] index_i,
    input  logic [1:0]                     valid_i,
    input  logic                           touch_i,
    input  logic                           touch_way_i,
    input  logic                           tick_i,
    output logic                           victim_o
);
    import icache_pkg::*;

    localparam logic [AGE_W-1:0] AGE_MAX = {AGE_W{1'b1}};

    logic [AGE_W-1:0] age_q [NUM_WAYS][NUM_SETS];
    logic [AGE_W-1:0] age0;
    logic [AGE_W-1:0] age1;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    age_q[w][s] <= '0;
                end
            end
        end else begin
            // every delivery ages all lines
            if (tick_i) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    for (int s = 0; s < NUM_SETS; s++) begin
                        if (age_q[w][s] != AGE_MAX) begin
                            age_q[w][s] <= age_q[w][s] + 1'b1;
                        end
                    end
                end
            end
            // touched way becomes youngest, wins over the tick
            if (touch_i) begin
                age_q[touch_way_i][index_i] <= '0;
            end
        end
    end

    assign age0 = age_q[0][index_i];
    assign age1 = age_q[1][index_i];

    always_comb begin
        if (!valid_i[0]) begin
            victim_o = 1'b0;
        end else if (!valid_i[1]) begin
            victim_o = 1'b1;
        end else begin
            victim_o = (age0 >= age1) ? 1'b0 : 1'b1;
        end
    end

endmodule

//--- src/icache_ctrl.sv
// request and refill FSM with fence sweep counter
// drives tag and line write commands and the age updates
module icache_ctrl (
    input  logic                             clk,
    input  logic                             arst_n_i,
    input  logic                             req_i,
    input  icache_pkg::fetch_addr_t          addr_i,
    input  logic                             stall_i,
    input  logic                             fence_i,
    input  icache_pkg::lookup_t              hit_i,
    input  logic                             victim_i,
    input  logic [63:0]                      mem_rdata_i,
    input  logic                             mem_rvalid_i,
    output logic                             inst_valid_o,
    output logic                             mem_req_o,
    output logic [31:0]                      mem_addr_o,
    output logic [icache_pkg::INDEX_W-1:0]   rd_index_o,
    output icache_pkg::tag_wr_t              tag_wr_o,
    output icache_pkg::line_wr_t             line_wr_o,
    output logic                             touch_o,
    output logic                             touch_way_o,
    output logic                             tick_o
);
    import icache_pkg::*;

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    logic [INDEX_W:0] fence_cnt_q;
    logic             fence_active;
    logic             fence_wr;
    logic             refill_done;

    // sweep only runs from idle, msb set means all sets done
    assign fence_active = fence_i && ((state_q == IDLE) || (state_q == FENCE));
    assign fence_wr     = fence_active && !fence_cnt_q[INDEX_W];
    assign refill_done  = (state_q == REFILL) && mem_rvalid_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fence_cnt_q <= '0;
        end else if (!fence_i) begin
            fence_cnt_q <= '0;
        end else if (fence_wr) begin
            fence_cnt_q <= fence_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (fence_i) begin
                    state_d = FENCE;
                end else if (req_i) begin
                    state_d = LOOKUP;
                end
            end
            // stores sample the index on this edge
            LOOKUP:  state_d = COMPARE;
            COMPARE: state_d = hit_i.hit ? DELIVER : REFILL;
            DELIVER: begin
                if (!stall_i) begin
                    state_d = IDLE;
                end
            end
            // line written, look it up again
            REFILL: begin
                if (mem_rvalid_i) begin
                    state_d = LOOKUP;
                end
            end
            FENCE: begin
                if (!fence_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign inst_valid_o = (state_q == DELIVER) && !stall_i;
    assign mem_req_o    = (state_q == REFILL);
    assign mem_addr_o   = {addr_i.tag, addr_i.index, 3'b000};
    assign rd_index_o   = addr_i.index;

    // fence clears both ways, refill installs the victim
    always_comb begin
        tag_wr_o = '0;
        if (fence_wr) begin
            tag_wr_o.way_mask = '1;
            tag_wr_o.index    = fence_cnt_q[INDEX_W-1:0];
        end else if (refill_done) begin
            tag_wr_o.way_mask    = victim_i ? 2'b10 : 2'b01;
            tag_wr_o.index       = addr_i.index;
            tag_wr_o.entry.valid = 1'b1;
            tag_wr_o.entry.tag   = addr_i.tag;
        end
    end

    always_comb begin
        line_wr_o.we    = refill_done;
        line_wr_o.way   = victim_i;
        line_wr_o.index = addr_i.index;
        line_wr_o.data  = mem_rdata_i;
    end

    // age update on delivery and on fill
    assign touch_o     = inst_valid_o || refill_done;
    assign touch_way_o = refill_done ? victim_i : hit_i.way;
    assign tick_o      = inst_valid_o;

endmodule

//--- src/icache_data_store.sv
// 64-bit line arrays for both ways
// registered read of the set and 32-bit word select
module icache_data_store (
    input  logic                           clk,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index_i,
    input  logic                           way_i,
    input  logic                           word_sel_i,
    input  icache_pkg::line_wr_t           line_wr_i,
    output logic [31:0]                    inst_o
);
    import icache_pkg::*;

    logic [63:0] rd_line_q [NUM_WAYS];
    logic [63:0] sel_line;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic [63:0] line_mem [NUM_SETS];

        // refill writes one whole line into the victim way
        always_ff @(posedge clk) begin
            if (line_wr_i.we && (line_wr_i.way == w)) begin
                line_mem[line_wr_i.index] <= line_wr_i.data;
            end
        end

        always_ff @(posedge clk) begin
            rd_line_q[w] <= line_mem[rd_index_i];
        end
    end

    assign sel_line = rd_line_q[way_i];

    // upper half holds the word at offset 4
    assign inst_o = word_sel_i ? sel_line[63:32] : sel_line[31:0];

endmodule

//--- src/icache_pkg.sv
// instruction cache geometry, address fields, tag and line write commands
// plus the controller state encoding
package icache_pkg;

    // cache geometry
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int NUM_SETS = 64;
    localparam int NUM_WAYS = 2;

    // fetch address split into cache fields
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic               word_sel;
        logic [1:0]         byte_off;
    } fetch_addr_t;

    // one tag array entry
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // result of the two-way compare
    typedef struct packed {
        logic hit;
        logic way;
    } lookup_t;

    // tag store write, both mask bits set during a fence sweep
    typedef struct packed {
        logic [NUM_WAYS-1:0] way_mask;
        logic [INDEX_W-1:0]  index;
        tag_entry_t          entry;
    } tag_wr_t;

    // data store write of one full line
    typedef struct packed {
        logic               we;
        logic               way;
        logic [INDEX_W-1:0] index;
        logic [63:0]        data;
    } line_wr_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOOKUP  = 3'd1,
        COMPARE = 3'd2,
        DELIVER = 3'd3,
        REFILL  = 3'd4,
        FENCE   = 3'd5
    } ctrl_state_e;

endpackage

//--- src/icache_tag_store.sv
// valid and tag arrays for both ways
// registered read of the set and two-way hit compare
module icache_tag_store (
    input  logic                           clk,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index_i,
    input  logic [icache_pkg::TAG_W-1:0]   tag_i,
    input  icache_pkg::tag_wr_t            tag_wr_i,
    output icache_pkg::lookup_t            hit_o,
    output logic [1:0]                     valid_o
);
    import icache_pkg::*;

    tag_entry_t          rd_entry_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] match;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        tag_entry_t tag_mem [NUM_SETS];

        // write from fence or refill
        always_ff @(posedge clk) begin
            if (tag_wr_i.way_mask[w]) begin
                tag_mem[tag_wr_i.index] <= tag_wr_i.entry;
            end
        end

        // read every cycle, the index is held by the core
        always_ff @(posedge clk) begin
            rd_entry_q[w] <= tag_mem[rd_index_i];
        end

        assign match[w]   = rd_entry_q[w].valid && (rd_entry_q[w].tag == tag_i);
        assign valid_o[w] = rd_entry_q[w].valid;
    end

    // at most one way matches after a clean fill
    always_comb begin
        hit_o.hit = |match;
        hit_o.way = match[1];
    end

endmodule

//--- src/icache_top.sv
// two-way instruction cache top level
// connects controller, tag store, age tracker and data store
module icache_top #(
    parameter int AGE_W = 3
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    req_i,
    input  icache_pkg::fetch_addr_t addr_i,
    input  logic                    stall_i,
    input  logic                    fence_i,
    input  logic [63:0]             mem_rdata_i,
    input  logic                    mem_rvalid_i,
    output logic [31:0]             inst_o,
    output logic                    inst_valid_o,
    output logic                    mem_req_o,
    output logic [31:0]             mem_addr_o
);
    import icache_pkg::*;

    logic [INDEX_W-1:0]  rd_index;
    lookup_t             hit;
    logic [NUM_WAYS-1:0] valid;
    logic                victim;
    tag_wr_t             tag_wr;
    line_wr_t            line_wr;
    logic                touch;
    logic                touch_way;
    logic                tick;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .stall_i      (stall_i),
        .fence_i      (fence_i),
        .hit_i        (hit),
        .victim_i     (victim),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i),
        .inst_valid_o (inst_valid_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .rd_index_o   (rd_index),
        .tag_wr_o     (tag_wr),
        .line_wr_o    (line_wr),
        .touch_o      (touch),
        .touch_way_o  (touch_way),
        .tick_o       (tick)
    );

    icache_tag_store u_tag_store (
        .clk        (clk),
        .rd_index_i (rd_index),
        .tag_i      (addr_i.tag),
        .tag_wr_i   (tag_wr),
        .hit_o      (hit),
        .valid_o    (valid)
    );

    icache_age_tracker #(
        .AGE_W (AGE_W)
    ) u_age_tracker (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .index_i     (rd_index),
        .valid_i     (valid),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .tick_i      (tick),
        .victim_o    (victim)
    );

    // word comes from the way that hit
    icache_data_store u_data_store (
        .clk        (clk),
        .rd_index_i (rd_index),
        .way_i      (hit.way),
        .word_sel_i (addr_i.word_sel),
        .line_wr_i  (line_wr),
        .inst_o     (inst_o)
    );

endmodule

//--- verification/icache_tb.sv
// testbench for the two-way instruction cache
// trace replay against a memory model with random latency and a watchdog
module icache_tb;
    import icache_pkg::*;

    localparam int TRACE_ENTRIES = 21;
    localparam int FENCE_CYCLES  = 70;
    localparam int STALL_CYCLES  = 8;
    localparam int HIT_LATENCY   = 3;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        req_i;
    fetch_addr_t addr_i;
    logic        stall_i;
    logic        fence_i;
    logic [63:0] mem_rdata_i;
    logic        mem_rvalid_i;
    logic [31:0] inst_o;
    logic        inst_valid_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;

    logic [31:0] trace_mem [0:4*TRACE_ENTRIES-1];
    logic [31:0] lfsr_q       = 32'hae47aa48;
    int          n_entries    = 0;
    int          check_errors = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    icache_top #(
        .AGE_W (3)
    ) UUT (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .stall_i      (stall_i),
        .fence_i      (fence_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i),
        .inst_o       (inst_o),
        .inst_valid_o (inst_valid_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o)
    );

    always #50 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = (value << 1) | lfsr_q[0];
        end
    endtask

    // memory model answering after 1 to 8 cycles
    initial begin
        int          delay;
        logic [31:0] line;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(negedge clk);
            if (mem_req_o === 1'b1) begin
                line = mem_addr_o;
                take_bits(3, delay);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mem_rdata_i  <= {~(line + 32'd4), line};
                mem_rvalid_i <= 1'b1;
                @(posedge clk);
                mem_rvalid_i <= 1'b0;
            end
        end
    end

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (check_errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    // one cycle of a fetch with the memory address checked on the first request
    task automatic sample_cycle(input string name, input logic [31:0] addr,
                                inout logic miss_seen);
        @(negedge clk);
        if (mem_req_o === 1'b1) begin
            if (!miss_seen) begin
                assert (mem_addr_o == {addr[31:3], 3'b000}) else begin
                    $display("ERR %s mem_addr expected %h actual %h",
                             name, {addr[31:3], 3'b000}, mem_addr_o);
                    check_errors++;
                end
            end
            miss_seen = 1'b1;
        end
    endtask

    task automatic run_fetch(input int idx, input logic [31:0] addr,
                             input logic [31:0] exp_word, input logic exp_miss,
                             input bit stalled);
        string       name;
        int          cycles;
        int          errs_before;
        logic        miss_seen;
        logic [31:0] got;
        name        = $sformatf("%s_%0d_%h", stalled ? "stall_fetch" : "fetch", idx, addr);
        errs_before = check_errors;
        miss_seen   = 1'b0;
        cycles      = 0;
        @(posedge clk);
        req_i   <= 1'b1;
        addr_i  <= addr;
        stall_i <= stalled;
        // accepting edge
        @(posedge clk);
        if (stalled) begin
            repeat (STALL_CYCLES) begin
                sample_cycle(name, addr, miss_seen);
                assert (inst_valid_o !== 1'b1) else begin
                    $display("%s: inst_valid_o pulsed while stall_i was high", name);
                    check_errors++;
                end
            end
            @(posedge clk);
            stall_i <= 1'b0;
        end
        do begin
            sample_cycle(name, addr, miss_seen);
            cycles++;
        end while (inst_valid_o !== 1'b1);
        got = inst_o;
        @(posedge clk);
        req_i <= 1'b0;
        @(negedge clk);
        assert (inst_valid_o !== 1'b1) else begin
            $display("%s: inst_valid_o stayed high for more than one cycle", name);
            check_errors++;
        end
        assert (got == exp_word) else begin
            $display("ERR %s word expected %h actual %h", name, exp_word, got);
            check_errors++;
        end
        assert (miss_seen == exp_miss) else begin
            $display("ERR %s miss expected %0d actual %0d", name, exp_miss, miss_seen);
            check_errors++;
        end
        if (!stalled && !exp_miss) begin
            assert (cycles == HIT_LATENCY) else begin
                $display("ERR %s hit latency expected %0d actual %0d",
                         name, HIT_LATENCY, cycles);
                check_errors++;
            end
        end
        report_test(name, errs_before);
    endtask

    task automatic run_fence(input int idx);
        string name;
        int    errs_before;
        name        = $sformatf("fence_%0d", idx);
        errs_before = check_errors;
        // request offered at the last address while the fence is held
        @(posedge clk);
        fence_i <= 1'b1;
        req_i   <= 1'b1;
        repeat (FENCE_CYCLES) begin
            @(negedge clk);
            assert (inst_valid_o !== 1'b1 && mem_req_o !== 1'b1) else begin
                $display("%s: cache answered or went to memory during the fence", name);
                check_errors++;
            end
        end
        @(posedge clk);
        req_i <= 1'b0;
        @(posedge clk);
        fence_i <= 1'b0;
        report_test(name, errs_before);
    endtask

    initial begin
        logic [31:0] op;
        arst_n_i = 1'b0;
        req_i    = 1'b0;
        addr_i   = '0;
        stall_i  = 1'b0;
        fence_i  = 1'b0;
        $readmemh("verification/icache_trace.txt", trace_mem);
        while (n_entries < TRACE_ENTRIES && trace_mem[4*n_entries] != 32'hf) begin
            n_entries++;
        end
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            op = trace_mem[4*i];
            case (op)
                32'h0: run_fetch(i, trace_mem[4*i+1], trace_mem[4*i+2], trace_mem[4*i+3][0], 1'b0);
                32'h1: run_fence(i);
                32'h2: run_fetch(i, trace_mem[4*i+1], trace_mem[4*i+2], trace_mem[4*i+3][0], 1'b1);
                default: begin
                    $display("trace entry %0d has an unknown operation %h", i, op);
                    tests_failed++;
                end
            endcase
        end
        $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 tests_run, tests_run - tests_failed, tests_failed, check_errors);
        if (n_entries > 0 && check_errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // run limit scales with the trace length
    initial begin
        wait (n_entries > 0);
        repeat (n_entries * 200 + 1000) @(posedge clk);
        $display("run timed out after %0d cycles", n_entries * 200 + 1000);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- verification/icache_trace.txt
// columns: op, address, expected word, expected miss flag
// op 0 fetch, 1 fence, 2 fetch with stall held, f end of trace
1 00000000 00000000 0
// first fetch, then the other word of the same line
0 00001040 00001040 1
0 00001044 ffffefbb 0
// second tag in set 8 fills the other way
0 00002040 00002040 1
0 00001040 00001040 0
0 00002044 ffffdfbb 0
// third tag evicts the older way
0 00003040 00003040 1
0 00002040 00002040 0
0 00001044 ffffefbb 1
0 00002044 ffffdfbb 0
// stall on a hit and on a miss
2 00001040 00001040 0
0 00000100 00000100 1
0 00000104 fffffefb 0
2 00000abc fffff543 1
// fence, everything misses again
1 00000000 00000000 0
0 00001040 00001040 1
0 00002044 ffffdfbb 1
0 00000104 fffffefb 1
0 00000ab8 00000ab8 1
0 00000abc fffff543 0
f 00000000 00000000 0
